//--- dram_axi_top.f
hdl/dram_ctrl_pkg.sv
hdl/axi_slave_if.sv
hdl/dram_pins_if.sv
hdl/dram_axi_ctrl.sv
hdl/dram_array.sv
hdl/dram_axi_top.sv
sim/dram_ctrl_checker.sv
sim/tb_dram_axi_top.sv

//--- hdl/axi_slave_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi_slave_if
  import dram_ctrl_pkg::*;
();

  // Write address
  axi_id_t   awid;
  axi_addr_t awaddr;
  axi_len_t  awlen;
  logic      awvalid;
  logic      awready;

  // Write data
  axi_data_t wdata;
  axi_strb_t wstrb;
  logic      wlast;
  logic      wvalid;
  logic      wready;

  // Write response
  axi_id_t   bid;
  axi_resp_t bresp;
  logic      bvalid;
  logic      bready;

  // Read address
  axi_id_t   arid;
  axi_addr_t araddr;
  axi_len_t  arlen;
  logic      arvalid;
  logic      arready;

  // Read data
  axi_id_t   rid;
  axi_data_t rdata;
  axi_resp_t rresp;
  logic      rlast;
  logic      rvalid;
  logic      rready;

  modport master (
    output awid, awaddr, awlen, awvalid, wdata, wstrb, wlast, wvalid, bready,
    output arid, araddr, arlen, arvalid, rready,
    input  awready, wready, bid, bresp, bvalid, arready, rid, rdata, rresp, rlast, rvalid
  );

  modport slave (
    input  awid, awaddr, awlen, awvalid, wdata, wstrb, wlast, wvalid, bready,
    input  arid, araddr, arlen, arvalid, rready,
    output awready, wready, bid, bresp, bvalid, arready, rid, rdata, rresp, rlast, rvalid
  );

endinterface

`default_nettype wire

//--- hdl/dram_array.sv
`timescale 1ns/1ps
`default_nettype none

module dram_array
  import dram_ctrl_pkg::*;
#(
  parameter int cas_latency   = 2,
  parameter int mem_addr_bits = 12
) (
  input  logic         clk,
  input  logic         rstn,
  dram_pins_if.device  dram
);

  logic [axi_strb_bits-1:0][7:0] mem [2**mem_addr_bits];

  logic [dram_row_bits-1:0] row_q;
  logic                     open_q;
  logic [mem_addr_bits-1:0] idx;

  logic cmd_act;
  logic cmd_pre;
  logic cmd_wr;
  logic cmd_rd;

  // Read return pipeline
  logic      [cas_latency-1:0] valid_sr;
  axi_data_t                   data_sr [cas_latency];

  // Command decode from the strobes
  assign cmd_act = ~dram.csn & ~dram.rasn & dram.casn & (&dram.wen);
  assign cmd_pre = ~dram.csn & ~dram.rasn & dram.casn & ~(|dram.wen);
  assign cmd_wr  = ~dram.csn & dram.rasn & ~dram.casn & ~(&dram.wen) & open_q;
  assign cmd_rd  = ~dram.csn & dram.rasn & ~dram.casn & (&dram.wen) & open_q;

  assign idx = mem_addr_bits'({row_q, dram.a[dram_col_bits-1:0]});

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      open_q <= 1'b0;
    end else if (cmd_act) begin
      open_q <= 1'b1;
    end else if (cmd_pre) begin
      open_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_act) begin
      row_q <= dram.a;
    end
  end

  // Byte writes and read sampling
  always_ff @(posedge clk) begin
    for (int i = 0; i < axi_strb_bits; i++) begin
      if (cmd_wr && !dram.wen[i]) begin
        mem[idx][i] <= dram.d[8*i +: 8];
      end
    end
    data_sr[0] <= mem[idx];
    for (int k = 1; k < cas_latency; k++) begin
      data_sr[k] <= data_sr[k-1];
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      valid_sr <= '0;
    end else begin
      valid_sr[0] <= cmd_rd;
      for (int k = 1; k < cas_latency; k++) begin
        valid_sr[k] <= valid_sr[k-1];
      end
    end
  end

  assign dram.q       = data_sr[cas_latency-1];
  assign dram.q_valid = valid_sr[cas_latency-1];

endmodule

`default_nettype wire

//--- hdl/dram_axi_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dram_axi_ctrl
  import dram_ctrl_pkg::*;
#(
  parameter int t_rcd = 3
) (
  input  logic              clk,
  input  logic              rstn,
  axi_slave_if.slave        axi,
  dram_pins_if.controller   dram
);

  localparam int rcd_bits = $clog2(t_rcd + 1);

  ctrl_state_t state, next_state;

  // Captured transaction
  axi_id_t    id_q;
  axi_len_t   len_q;
  dram_addr_u addr_q;
  axi_data_t  wdata_q;
  axi_strb_t  wstrb_q;
  logic       is_write;

  logic [rcd_bits-1:0] delay_cnt;
  axi_len_t            beat;
  axi_data_t           rdata_q;

  logic aw_hs;
  logic ar_hs;
  logic b_hs;
  logic r_hs;
  logic last_beat;
  logic [dram_col_bits-1:0] col_sent;

  assign aw_hs = axi.awvalid & axi.awready;
  assign ar_hs = axi.arvalid & axi.arready;
  assign b_hs  = axi.bvalid & axi.bready;
  assign r_hs  = axi.rvalid & axi.rready;

  assign last_beat = (beat == len_q);
  assign col_sent  = addr_q.fields.col + {6'b0, beat};

  // Handshake outputs, write wins in idle
  assign axi.awready = (state == st_idle) & axi.awvalid & axi.wvalid;
  assign axi.wready  = (state == st_idle) & axi.awvalid & axi.wvalid;
  assign axi.arready = (state == st_idle) & ~axi.awvalid;
  assign axi.bvalid  = (state == st_write_resp);
  assign axi.rvalid  = (state == st_read_resp);

  assign axi.bid   = id_q;
  assign axi.rid   = id_q;
  assign axi.bresp = resp_okay;
  assign axi.rresp = resp_okay;
  assign axi.rdata = rdata_q;
  assign axi.rlast = last_beat;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    unique case (state)
      st_idle: begin
        if (aw_hs || ar_hs) begin
          next_state = st_activate;
        end
      end
      st_activate: next_state = st_rcd_wait;
      st_rcd_wait: begin
        if (delay_cnt == '0) begin
          next_state = is_write ? st_write_cas : st_read_cas;
        end
      end
      st_read_cas: next_state = st_read_wait;
      st_read_wait: begin
        if (dram.q_valid) begin
          next_state = st_read_resp;
        end
      end
      st_read_resp: begin
        if (r_hs) begin
          next_state = last_beat ? st_precharge : st_read_cas;
        end
      end
      st_write_cas: next_state = st_write_resp;
      st_write_resp: begin
        if (b_hs) begin
          next_state = st_precharge;
        end
      end
      st_precharge: next_state = st_idle;
      default: next_state = st_idle;
    endcase
  end

  // Transaction capture on the accepting edge
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      id_q       <= axi.awid;
      len_q      <= '0;
      addr_q.raw <= axi.awaddr;
      wdata_q    <= axi.wdata;
      wstrb_q    <= axi.wstrb;
    end else if (ar_hs) begin
      id_q       <= axi.arid;
      len_q      <= axi.arlen;
      addr_q.raw <= axi.araddr;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      is_write  <= 1'b0;
      delay_cnt <= '0;
      beat      <= '0;
    end else begin
      if (aw_hs) begin
        is_write <= 1'b1;
      end else if (ar_hs) begin
        is_write <= 1'b0;
      end

      // rcd_wait lasts t_rcd cycles
      if (state == st_activate) begin
        delay_cnt <= rcd_bits'(t_rcd - 1);
      end else if (state == st_rcd_wait && delay_cnt != '0) begin
        delay_cnt <= delay_cnt - 1'b1;
      end

      if (aw_hs || ar_hs) begin
        beat <= '0;
      end else if (r_hs && !last_beat) begin
        beat <= beat + 1'b1;
      end
    end
  end

  // Read word held stable through read_resp
  always_ff @(posedge clk) begin
    if (state == st_read_wait && dram.q_valid) begin
      rdata_q <= dram.q;
    end
  end

  // Pin encoding per state
  always_comb begin
    dram.csn  = 1'b1;
    dram.rasn = 1'b1;
    dram.casn = 1'b1;
    dram.wen  = '1;
    dram.a    = addr_q.fields.row;
    dram.d    = wdata_q;
    unique case (state)
      st_activate: begin
        dram.csn  = 1'b0;
        dram.rasn = 1'b0;
      end
      st_write_cas: begin
        dram.csn  = 1'b0;
        dram.casn = 1'b0;
        dram.wen  = ~wstrb_q;
        dram.a    = {1'b0, col_sent};
      end
      st_read_cas: begin
        dram.csn  = 1'b0;
        dram.casn = 1'b0;
        dram.a    = {1'b0, col_sent};
      end
      st_precharge: begin
        dram.csn  = 1'b0;
        dram.rasn = 1'b0;
        dram.wen  = '0;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/dram_axi_top.sv
`timescale 1ns/1ps
`default_nettype none

module dram_axi_top
  import dram_ctrl_pkg::*;
#(
  parameter int t_rcd         = 3,
  parameter int cas_latency   = 2,
  parameter int mem_addr_bits = 12
) (
  input  logic      clk,
  input  logic      rstn,
  // Write address
  input  axi_id_t   awid,
  input  axi_addr_t awaddr,
  input  axi_len_t  awlen,
  input  logic      awvalid,
  output logic      awready,
  // Write data
  input  axi_data_t wdata,
  input  axi_strb_t wstrb,
  input  logic      wlast,
  input  logic      wvalid,
  output logic      wready,
  // Write response
  output axi_id_t   bid,
  output axi_resp_t bresp,
  output logic      bvalid,
  input  logic      bready,
  // Read address
  input  axi_id_t   arid,
  input  axi_addr_t araddr,
  input  axi_len_t  arlen,
  input  logic      arvalid,
  output logic      arready,
  // Read data
  output axi_id_t   rid,
  output axi_data_t rdata,
  output axi_resp_t rresp,
  output logic      rlast,
  output logic      rvalid,
  input  logic      rready
);

  axi_slave_if axi ();
  dram_pins_if dram ();

  assign axi.awid    = awid;
  assign axi.awaddr  = awaddr;
  assign axi.awlen   = awlen;
  assign axi.awvalid = awvalid;
  assign awready     = axi.awready;

  assign axi.wdata  = wdata;
  assign axi.wstrb  = wstrb;
  assign axi.wlast  = wlast;
  assign axi.wvalid = wvalid;
  assign wready     = axi.wready;

  assign bid        = axi.bid;
  assign bresp      = axi.bresp;
  assign bvalid     = axi.bvalid;
  assign axi.bready = bready;

  assign axi.arid    = arid;
  assign axi.araddr  = araddr;
  assign axi.arlen   = arlen;
  assign axi.arvalid = arvalid;
  assign arready     = axi.arready;

  assign rid        = axi.rid;
  assign rdata      = axi.rdata;
  assign rresp      = axi.rresp;
  assign rlast      = axi.rlast;
  assign rvalid     = axi.rvalid;
  assign axi.rready = rready;

  dram_axi_ctrl #(
    .t_rcd (t_rcd)
  ) u_ctrl (
    .clk  (clk),
    .rstn (rstn),
    .axi  (axi.slave),
    .dram (dram.controller)
  );

  dram_array #(
    .cas_latency   (cas_latency),
    .mem_addr_bits (mem_addr_bits)
  ) u_array (
    .clk  (clk),
    .rstn (rstn),
    .dram (dram.device)
  );

endmodule

`default_nettype wire

//--- hdl/dram_ctrl_pkg.sv
`default_nettype none

package dram_ctrl_pkg;

  // AXI field widths
  localparam int axi_id_bits   = 4;
  localparam int axi_len_bits  = 4;
  localparam int axi_data_bits = 32;
  localparam int axi_addr_bits = 32;
  localparam int axi_strb_bits = axi_data_bits / 8;
  localparam int axi_resp_bits = 2;

  // DRAM pin widths
  localparam int dram_a_bits   = 11;
  localparam int dram_row_bits = 11;
  localparam int dram_col_bits = 10;

  typedef logic [axi_id_bits-1:0]   axi_id_t;
  typedef logic [axi_len_bits-1:0]  axi_len_t;
  typedef logic [axi_data_bits-1:0] axi_data_t;
  typedef logic [axi_strb_bits-1:0] axi_strb_t;
  typedef logic [axi_resp_bits-1:0] axi_resp_t;
  typedef logic [axi_addr_bits-1:0] axi_addr_t;

  typedef logic [dram_a_bits-1:0]   dram_a_t;
  typedef logic [axi_strb_bits-1:0] dram_wen_t;

  localparam axi_resp_t resp_okay = 2'b00;

  // Byte address split into DRAM row and column
  typedef struct packed {
    logic [8:0]               pad;
    logic [dram_row_bits-1:0] row;
    logic [dram_col_bits-1:0] col;
    logic [1:0]               byte_off;
  } dram_addr_fields_t;

  typedef union packed {
    axi_addr_t         raw;
    dram_addr_fields_t fields;
  } dram_addr_u;

  // One-hot controller state
  typedef enum logic [8:0] {
    st_idle       = 9'b0_0000_0001,
    st_activate   = 9'b0_0000_0010,
    st_rcd_wait   = 9'b0_0000_0100,
    st_read_cas   = 9'b0_0000_1000,
    st_read_wait  = 9'b0_0001_0000,
    st_read_resp  = 9'b0_0010_0000,
    st_write_cas  = 9'b0_0100_0000,
    st_write_resp = 9'b0_1000_0000,
    st_precharge  = 9'b1_0000_0000
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/dram_pins_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dram_pins_if
  import dram_ctrl_pkg::*;
();

  // Active-low command strobes
  logic      csn;
  logic      rasn;
  logic      casn;
  dram_wen_t wen;

  dram_a_t   a;
  axi_data_t d;

  // Read return, one-cycle valid pulse
  axi_data_t q;
  logic      q_valid;

  modport controller (
    output csn, rasn, casn, wen, a, d,
    input  q, q_valid
  );

  modport device (
    input  csn, rasn, casn, wen, a, d,
    output q, q_valid
  );

endinterface

`default_nettype wire

//--- sim/dram_cases.txt
// op id addr count strb, then count hex words (write data or expected read beats)
// W writes consecutive words, R reads one burst, C writes while a read waits
W 1 00000000 16 f
11223300 11223301 11223302 11223303 11223304 11223305 11223306 11223307
11223308 11223309 1122330a 1122330b 1122330c 1122330d 1122330e 1122330f
R 2 00000000 1 0
11223300
W 3 00000014 1 5
aabbccdd
R 4 00000014 1 0
11bb33dd
R 5 00000008 4 0
11223302 11223303 11223304 11bb33dd
R 6 00000000 16 0
11223300 11223301 11223302 11223303 11223304 11bb33dd 11223306 11223307
11223308 11223309 1122330a 1122330b 1122330c 1122330d 1122330e 1122330f
W 7 0000100c 1 f
cafe0101
W 8 0000200c 1 f
cafe0202
R 9 0000200c 1 0
cafe0202
R a 0000100c 1 0
cafe0101
R b 0000000c 1 0
11223303
C c 00003040 1 f
5a5a0303

//--- sim/dram_ctrl_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dram_ctrl_checker
  import dram_ctrl_pkg::*;
#(
  parameter int t_rcd = 3
) (
  input logic      clk,
  input logic      rstn,
  input logic      bvalid,
  input logic      bready,
  input logic      rvalid,
  input logic      rready,
  input axi_data_t rdata,
  input logic      csn,
  input logic      rasn,
  input logic      casn,
  input dram_wen_t wen
);

  logic act;
  logic col;
  int   since_act;

  assign act = ~csn & ~rasn & casn & (&wen);
  assign col = ~csn & ~casn;

  // Cycles since the last activate, saturating at t_rcd
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      since_act <= t_rcd;
    end else if (act) begin
      since_act <= 0;
    end else if (since_act < t_rcd) begin
      since_act <= since_act + 1;
    end
  end

  bvalid_held: assert property (@(posedge clk) disable iff (!rstn)
    bvalid && !bready |=> bvalid) else $error("BVALID dropped before BREADY");

  rvalid_held: assert property (@(posedge clk) disable iff (!rstn)
    rvalid && !rready |=> rvalid) else $error("RVALID dropped before RREADY");

  rdata_stable: assert property (@(posedge clk) disable iff (!rstn)
    rvalid && !rready |=> $stable(rdata)) else $error("RDATA changed while RVALID held");

  ras_cas_apart: assert property (@(posedge clk) disable iff (!rstn)
    rasn || casn) else $error("RASN and CASN low in the same cycle");

  rcd_respected: assert property (@(posedge clk) disable iff (!rstn)
    col |-> since_act >= t_rcd) else $error("Column command inside tRCD window");

endmodule

`default_nettype wire

//--- sim/tb_dram_axi_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dram_axi_top
  import dram_ctrl_pkg::*;
();

  localparam int t_rcd   = 3;
  localparam int timeout = 200;

  logic      clk = 1'b0;
  logic      rstn;
  axi_id_t   awid, arid, bid, rid;
  axi_addr_t awaddr, araddr;
  axi_len_t  awlen, arlen;
  axi_data_t wdata, rdata;
  axi_strb_t wstrb;
  axi_resp_t bresp, rresp;
  logic      awvalid, awready, wlast, wvalid, wready;
  logic      bvalid, bready, arvalid, arready;
  logic      rlast, rvalid, rready;

  int        errors  = 0;
  int        cases   = 0;
  logic      aborted = 1'b0;
  // Write data or expected read beats of the current case
  axi_data_t words [16];

  always #20 clk = ~clk;

  dram_axi_top #(
    .t_rcd         (t_rcd),
    .cas_latency   (2),
    .mem_addr_bits (12)
  ) DUT (.*);

  bind dram_axi_ctrl dram_ctrl_checker #(.t_rcd(t_rcd)) u_checker (
    .clk    (clk),
    .rstn   (rstn),
    .bvalid (axi.bvalid),
    .bready (axi.bready),
    .rvalid (axi.rvalid),
    .rready (axi.rready),
    .rdata  (axi.rdata),
    .csn    (dram.csn),
    .rasn   (dram.rasn),
    .casn   (dram.casn),
    .wen    (dram.wen)
  );

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[FAIL] time %0t %s: got %0h, expected %0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic check_data(input string name, input axi_data_t got, input axi_data_t exp);
    if (got !== exp) begin
      report_mismatch(name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
    if (got !== exp) begin
      report_mismatch(name, got, exp);
    end
  endtask

  task automatic check_id(input string name, input axi_id_t got, input axi_id_t exp);
    if (got !== exp) begin
      report_mismatch(name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_mismatch(name, got, exp);
    end
  endtask

  task automatic check_cycles(input string name, input int got, input int exp);
    if (got != exp) begin
      report_mismatch(name, got, exp);
    end
  endtask

  function automatic logic sig_level(input int sel);
    case (sel)
      0:       return awready;
      1:       return arready;
      2:       return bvalid;
      default: return rvalid;
    endcase
  endfunction

  // Returns at the first edge that sees the signal high, n counts the edges
  task automatic wait_high(input int sel, input string what, output int n);
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!sig_level(sel) && n < timeout);
    if (!sig_level(sel)) begin
      $display("Timeout: %s not seen within %0d cycles", what, timeout);
      aborted = 1'b1;
    end
  endtask

  // Random back-pressure of 0 to 3 cycles before the response transfer
  task automatic accept_resp(input logic is_read);
    int stall;
    stall = $urandom % 4;
    repeat (stall) @(posedge clk);
    if (is_read) begin
      rready <= 1'b1;
    end else begin
      bready <= 1'b1;
    end
    @(posedge clk);
    bready <= 1'b0;
    rready <= 1'b0;
  endtask

  task automatic write_word(input axi_id_t id, input axi_addr_t addr, input axi_data_t data,
                            input axi_strb_t strb, input logic with_ar);
    int n;
    awid    <= id;
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= strb;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    if (with_ar) begin
      arid    <= ~id;
      araddr  <= addr;
      arlen   <= '0;
      arvalid <= 1'b1;
    end
    wait_high(0, "AWREADY", n);
    if (aborted) return;
    // Write data is taken on the same edge as the address
    check_flag("wready", wready, 1'b1);
    // A read offered alongside must wait for the write
    check_flag("arready", arready, 1'b0);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    wait_high(2, "BVALID", n);
    if (aborted) return;
    // n counts to the edge that samples BVALID, one past its rise
    check_cycles("bvalid latency", n - 1, t_rcd + 2);
    check_id("bid", bid, id);
    check_resp("bresp", bresp, resp_okay);
    accept_resp(1'b0);
  endtask

  task automatic read_burst(input axi_id_t id, input axi_addr_t addr, input int count);
    int n;
    arid    <= id;
    araddr  <= addr;
    arlen   <= axi_len_t'(count - 1);
    arvalid <= 1'b1;
    wait_high(1, "ARREADY", n);
    if (aborted) return;
    arvalid <= 1'b0;
    for (int beat = 0; beat < count; beat++) begin
      wait_high(3, "RVALID", n);
      if (aborted) return;
      check_data($sformatf("rdata[%0d]", beat), rdata, words[beat]);
      check_id("rid", rid, id);
      check_resp("rresp", rresp, resp_okay);
      check_flag("rlast", rlast, beat == count - 1);
      accept_resp(1'b1);
    end
  endtask

  initial begin
    int               fd;
    int               rc;
    int               count;
    int               errors_before;
    logic [8*8-1:0]   tok;
    logic [8*128-1:0] line;
    axi_id_t          id;
    axi_addr_t        addr;
    axi_strb_t        strb;
    rc = $urandom(25);
    rstn    <= 1'b0;
    awid    <= '0;
    awaddr  <= '0;
    awlen   <= '0;
    awvalid <= 1'b0;
    wdata   <= '0;
    wstrb   <= '0;
    wlast   <= 1'b1;
    wvalid  <= 1'b0;
    bready  <= 1'b0;
    arid    <= '0;
    araddr  <= '0;
    arlen   <= '0;
    arvalid <= 1'b0;
    rready  <= 1'b0;
    fd = $fopen("sim/dram_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open sim/dram_cases.txt");
      aborted = 1'b1;
    end
    repeat (16) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);
    while (!aborted && $fscanf(fd, " %s", tok) == 1) begin
      if (tok == "//") begin
        rc = $fgets(line, fd);
      end else begin
        rc = $fscanf(fd, " %h %h %d %h", id, addr, count, strb);
        for (int i = 0; i < count; i++) begin
          rc = $fscanf(fd, " %h", words[i]);
        end
        errors_before = errors;
        case (tok)
          "W": begin
            for (int i = 0; i < count && !aborted; i++) begin
              write_word(id, addr + 4 * i, words[i], strb, 1'b0);
            end
          end
          "R": read_burst(id, addr, count);
          "C": begin
            write_word(id, addr, words[0], strb, 1'b1);
            if (!aborted) begin
              read_burst(~id, addr, 1);
            end
          end
          default: begin
            $display("Unknown operation in the cases file");
            aborted = 1'b1;
          end
        endcase
        cases++;
        $display("case %0d %c addr %h words %0d: %s", cases, tok[7:0], addr, count,
                 (errors == errors_before && !aborted) ? "ok" : "error");
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    $display("%0d cases run, %0d mismatches", cases, errors);
    if (errors == 0 && !aborted) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
